//--- design/loopers_params.svh
//////////////////////////////////////////////////
// Widths and instruction field positions
// Field layout is fixed for a 16-bit instruction
// Bits 7:6 are reserved and never decoded
//////////////////////////////////////////////////

`ifndef LOOPERS_PARAMS_SVH
`define LOOPERS_PARAMS_SVH

`define LOOPERS_DATA_W   16    // Data word width
`define LOOPERS_NREGS    8     // Register file depth

// Instruction fields
`define LOOPERS_MODE_MSB 15    // ALU mode, top bit
`define LOOPERS_MODE_LSB 13    // ALU mode, bottom bit
`define LOOPERS_INV_BIT  12    // Invert operand 2
`define LOOPERS_IMM_BIT  11    // Operand 2 from immediate
`define LOOPERS_RD_LSB   8     // Destination register
`define LOOPERS_RS_LSB   3     // Source register 1
`define LOOPERS_RT_LSB   0     // Source register 2

`endif

//--- design/loopers_pkg.sv
//////////////////////////////////////////////////
// Shared types of the execute pipeline
// Widths follow the params header
// Mode 001 is an add alias with no name of its own
//////////////////////////////////////////////////

`include "loopers_params.svh"

package loopers_pkg;

   //////////////////////////////////////////////////
   // Datapath types
   //////////////////////////////////////////////////

   typedef logic [`LOOPERS_DATA_W-1:0]        data_t;      // One data word
   typedef logic [$clog2(`LOOPERS_NREGS)-1:0] reg_addr_t;  // Register index
   typedef logic [2:0]                        alu_mode_t;  // Mode field

   // Whole instruction word, sized by the top field
   typedef logic [`LOOPERS_MODE_MSB:0] instr_t;

   //////////////////////////////////////////////////
   // ALU mode encodings
   //////////////////////////////////////////////////

   // Plain add, also reached by 001
   localparam alu_mode_t MODE_ADD  = 3'b000;

   // Add plus one
   // With invert set this is op1 - op2
   localparam alu_mode_t MODE_ADD1 = 3'b010;

   localparam alu_mode_t MODE_AND  = 3'b011;  // Bitwise and
   localparam alu_mode_t MODE_OR   = 3'b100;  // Bitwise or
   localparam alu_mode_t MODE_XOR  = 3'b101;  // Bitwise xor

   // Operand 2 unused
   localparam alu_mode_t MODE_NOT  = 3'b110;

   // Arithmetic right shift of op1
   // Amount is low bits of raw op2, never inverted
   localparam alu_mode_t MODE_SRA  = 3'b111;

endpackage

//--- design/reg_file.sv
//////////////////////////////////////////////////
// Eight word register file
// Reads are combinational, no write-through
// Same-cycle forwarding is left to decode bypass
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "loopers_params.svh"

module reg_file (
   input  logic                   clk,
   input  logic                   reset,
   input  loopers_pkg::reg_addr_t rs_addr,  // Read port 1
   input  loopers_pkg::reg_addr_t rt_addr,  // Read port 2
   output loopers_pkg::data_t     rs_data,
   output loopers_pkg::data_t     rt_data,
   input  logic                   wr_en,    // Writeback strobe
   input  loopers_pkg::reg_addr_t wr_addr,
   input  loopers_pkg::data_t     wr_data
);
   import loopers_pkg::*;

   data_t regs [`LOOPERS_NREGS];

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   // All words cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `LOOPERS_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;   // Visible from the next cycle
      end
   end

   //////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

endmodule

//--- design/alu.sv
//////////////////////////////////////////////////
// Execute stage, one clock edge
// Invert applies to op2 for all but the shift
// Shift amount uses the low bits of raw op2
// Output is zero while not enabled
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "loopers_params.svh"

module alu (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   alu_en,      // Valid op in this stage
   input  loopers_pkg::alu_mode_t alu_mode,
   input  logic                   alu_inv_rt,  // Invert operand 2
   input  loopers_pkg::reg_addr_t alu_rd,
   input  loopers_pkg::data_t     alu_op1,
   input  loopers_pkg::data_t     alu_op2,
   output loopers_pkg::data_t     alu_next,    // Combinational result
   output logic                   ex_valid,
   output loopers_pkg::reg_addr_t ex_rd,
   output loopers_pkg::data_t     ex_result
);
   import loopers_pkg::*;

   localparam int SHW = $clog2(`LOOPERS_DATA_W);  // Shift amount width

   data_t          op2_inv;
   data_t          sra_tab [`LOOPERS_DATA_W];
   logic [SHW-1:0] shamt;

   //////////////////////////////////////////////////
   // Operand prep
   //////////////////////////////////////////////////
   assign op2_inv = alu_op2 ^ {`LOOPERS_DATA_W{alu_inv_rt}};
   assign shamt   = alu_op2[SHW-1:0];   // Raw op2, invert ignored

   // One entry per shift amount
   for (genvar i = 0; i < `LOOPERS_DATA_W; i++) begin : g_sra
      assign sra_tab[i] = data_t'($signed(alu_op1) >>> i);  // Sign fill
   end

   //////////////////////////////////////////////////
   // Operation select
   //////////////////////////////////////////////////
   always_comb begin
      if (!alu_en) begin
         alu_next = '0;
      end else begin
         case (alu_mode)
            MODE_ADD, 3'b001: alu_next = alu_op1 + op2_inv;    // 001 aliases add
            MODE_ADD1: alu_next = alu_op1 + op2_inv + data_t'(1);  // Sub with invert
            MODE_AND:  alu_next = alu_op1 & op2_inv;
            MODE_OR:   alu_next = alu_op1 | op2_inv;
            MODE_XOR:  alu_next = alu_op1 ^ op2_inv;
            MODE_NOT:  alu_next = ~alu_op1;
            MODE_SRA:  alu_next = sra_tab[shamt];
            default:   alu_next = '0;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Stage 2 register
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         ex_valid  <= 1'b0;
         ex_rd     <= '0;
         ex_result <= '0;
      end else begin
         ex_valid  <= alu_en;
         ex_rd     <= alu_rd;
         ex_result <= alu_next;         // Zero on bubbles
      end
   end

endmodule

//--- design/instr_decode.sv
//////////////////////////////////////////////////
// Decode stage, one clock edge
// Bypass covers results one and two slots ahead
// Older results come from the register file reads
// Payload only loads on issue, valid every cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "loopers_params.svh"

module instr_decode (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  issue,      // New instruction this cycle
   input  loopers_pkg::instr_t   instr,
   input  loopers_pkg::data_t    imm,
   output loopers_pkg::reg_addr_t rs_addr,   // To register file
   output loopers_pkg::reg_addr_t rt_addr,
   input  loopers_pkg::data_t    rs_data,    // From register file
   input  loopers_pkg::data_t    rt_data,
   input  loopers_pkg::data_t    alu_next,   // ALU output, one ahead
   input  logic                  ex_valid,   // Execute register, two ahead
   input  loopers_pkg::reg_addr_t ex_rd,
   input  loopers_pkg::data_t    ex_result,
   output logic                  dec_valid,
   output loopers_pkg::alu_mode_t dec_mode,
   output logic                  dec_inv,
   output loopers_pkg::reg_addr_t dec_rd,
   output loopers_pkg::data_t    dec_op1,
   output loopers_pkg::data_t    dec_op2
);
   import loopers_pkg::*;

   alu_mode_t mode_f;
   logic      inv_f;
   logic      imm_f;
   reg_addr_t rd_f;
   data_t     rs_val;    // Resolved operand 1
   data_t     rt_val;    // Resolved rt before immediate mux
   data_t     op2_val;

   //////////////////////////////////////////////////
   // Field split
   //////////////////////////////////////////////////
   assign mode_f  = instr[`LOOPERS_MODE_MSB:`LOOPERS_MODE_LSB];
   assign inv_f   = instr[`LOOPERS_INV_BIT];
   assign imm_f   = instr[`LOOPERS_IMM_BIT];
   assign rd_f    = instr[`LOOPERS_RD_LSB +: $bits(reg_addr_t)];
   assign rs_addr = instr[`LOOPERS_RS_LSB +: $bits(reg_addr_t)];
   assign rt_addr = instr[`LOOPERS_RT_LSB +: $bits(reg_addr_t)];

   // Newest producer wins
   function automatic data_t bypass(input reg_addr_t addr, input data_t rf_data);
      if (dec_valid && dec_rd == addr)
         return alu_next;               // Instruction now in execute
      else if (ex_valid && ex_rd == addr)
         return ex_result;              // Being written back this cycle
      else
         return rf_data;
   endfunction

   always_comb begin
      rs_val  = bypass(rs_addr, rs_data);
      rt_val  = bypass(rt_addr, rt_data);
      op2_val = imm_f ? imm : rt_val;   // Immediate replaces rt
   end

   //////////////////////////////////////////////////
   // Stage 1 register
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         dec_valid <= 1'b0;
         dec_mode  <= '0;
         dec_inv   <= 1'b0;
         dec_rd    <= '0;
         dec_op1   <= '0;
         dec_op2   <= '0;
      end else begin
         dec_valid <= issue;            // Bubble when idle
         if (issue) begin
            dec_mode <= mode_f;
            dec_inv  <= inv_f;
            dec_rd   <= rd_f;
            dec_op1  <= rs_val;
            dec_op2  <= op2_val;
         end
      end
   end

endmodule

//--- design/loopers_exec_top.sv
//////////////////////////////////////////////////
// Three stage execute pipeline top
// Result appears two edges after issue
// No back-pressure, every result must be taken
//////////////////////////////////////////////////

`timescale 1ns/1ps

module loopers_exec_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   issue,         // One instruction per cycle max
   input  loopers_pkg::instr_t    instr,
   input  loopers_pkg::data_t     imm,
   output logic                   result_valid,  // Writeback strobe
   output loopers_pkg::reg_addr_t result_reg,
   output loopers_pkg::data_t     result
);
   import loopers_pkg::*;

   // Register file reads
   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   data_t     rs_data;
   data_t     rt_data;

   // Decode to execute
   logic      dec_valid;
   alu_mode_t dec_mode;
   logic      dec_inv;
   reg_addr_t dec_rd;
   data_t     dec_op1;
   data_t     dec_op2;

   // Execute to writeback
   data_t     alu_next;
   logic      ex_valid;
   reg_addr_t ex_rd;
   data_t     ex_result;

   //////////////////////////////////////////////////
   // Stage 1
   //////////////////////////////////////////////////
   instr_decode i_instr_decode (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .instr     (instr),
      .imm       (imm),
      .rs_addr   (rs_addr),
      .rt_addr   (rt_addr),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .alu_next  (alu_next),    // Bypass from execute
      .ex_valid  (ex_valid),    // Bypass from writeback
      .ex_rd     (ex_rd),
      .ex_result (ex_result),
      .dec_valid (dec_valid),
      .dec_mode  (dec_mode),
      .dec_inv   (dec_inv),
      .dec_rd    (dec_rd),
      .dec_op1   (dec_op1),
      .dec_op2   (dec_op2)
   );

   //////////////////////////////////////////////////
   // Stage 2
   //////////////////////////////////////////////////
   alu i_alu (
      .clk        (clk),
      .reset      (reset),
      .alu_en     (dec_valid),
      .alu_mode   (dec_mode),
      .alu_inv_rt (dec_inv),
      .alu_rd     (dec_rd),
      .alu_op1    (dec_op1),
      .alu_op2    (dec_op2),
      .alu_next   (alu_next),
      .ex_valid   (ex_valid),
      .ex_rd      (ex_rd),
      .ex_result  (ex_result)
   );

   //////////////////////////////////////////////////
   // Stage 3, writeback
   //////////////////////////////////////////////////
   reg_file i_reg_file (
      .clk     (clk),
      .reset   (reset),
      .rs_addr (rs_addr),
      .rt_addr (rt_addr),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wr_en   (ex_valid),      // Commit on the next edge
      .wr_addr (ex_rd),
      .wr_data (ex_result)
   );

   // Outputs straight from the execute register
   assign result_valid = ex_valid;
   assign result_reg   = ex_rd;
   assign result       = ex_result;

endmodule

//--- dv/loopers_exec_tb.sv
//////////////////////////////////////////////////
// Testbench for the three stage execute pipeline
// Model runs in program order, results due 2 edges
// after the issue edge, no back-pressure modeled
// Watchdog limit grows with TOTAL_ISSUES
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "loopers_params.svh"

module loopers_exec_tb;
   import loopers_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 8;
   localparam int TOTAL_ISSUES = 313;                   // Sum over all six tests
   localparam int WATCHDOG_CYC = TOTAL_ISSUES * 4 + 100;

   logic      clk;
   logic      reset;
   logic      issue;
   instr_t    instr;
   data_t     imm;
   logic      result_valid;
   reg_addr_t result_reg;
   data_t     result;

   logic [31:0] rng_state;
   data_t       model_regs [`LOOPERS_NREGS];   // Architectural state of the model
   reg_addr_t   exp_reg_q [$];                 // Pending results, oldest first
   data_t       exp_val_q [$];
   int          exp_edge_q [$];                // Edge that samples the result
   int          cyc;                           // Rising edges so far
   int          errors;
   int          checks;
   int          issued;
   int          tests_run;
   int          tests_passed;
   int          test_err_start;

   loopers_exec_top i_loopers_exec_top (
      .clk          (clk),
      .reset        (reset),
      .issue        (issue),
      .instr        (instr),
      .imm          (imm),
      .result_valid (result_valid),
      .result_reg   (result_reg),
      .result       (result)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   //////////////////////////////////////////////////
   // Random source and reference model
   //////////////////////////////////////////////////
   function logic [31:0] rand32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic instr_t make_instr(input alu_mode_t mode, input logic inv,
                                         input logic use_imm, input reg_addr_t rd,
                                         input reg_addr_t rs, input reg_addr_t rt);
      instr_t w;
      w = '0;                                            // Reserved bits stay zero
      w[`LOOPERS_MODE_MSB:`LOOPERS_MODE_LSB]     = mode;
      w[`LOOPERS_INV_BIT]                        = inv;
      w[`LOOPERS_IMM_BIT]                        = use_imm;
      w[`LOOPERS_RD_LSB +: $bits(reg_addr_t)]   = rd;
      w[`LOOPERS_RS_LSB +: $bits(reg_addr_t)]   = rs;
      w[`LOOPERS_RT_LSB +: $bits(reg_addr_t)]   = rt;
      return w;
   endfunction

   function automatic data_t model_alu(input alu_mode_t mode, input logic inv,
                                       input data_t a, input data_t b);
      data_t bx;
      data_t r;
      int    amt;
      bx = inv ? ~b : b;
      case (mode)
         MODE_ADD, 3'b001: r = a + bx;
         MODE_ADD1:        r = a + bx + 16'd1;           // a - b when inverted
         MODE_AND:         r = a & bx;
         MODE_OR:          r = a | bx;
         MODE_XOR:         r = a ^ bx;
         MODE_NOT:         r = ~a;
         MODE_SRA: begin
            // One bit at a time, sign bit refilled
            r   = a;
            amt = int'(b[3:0]);                          // Raw operand, never inverted
            for (int i = 0; i < amt; i++) begin
               r = {r[`LOOPERS_DATA_W-1], r[`LOOPERS_DATA_W-1:1]};
            end
         end
         default:          r = '0;
      endcase
      return r;
   endfunction

   // Apply one instruction to the model and queue its result
   task automatic model_issue(input instr_t word, input data_t imm_val);
      reg_addr_t rd;
      data_t     op1;
      data_t     op2;
      data_t     val;
      rd  = word[`LOOPERS_RD_LSB +: $bits(reg_addr_t)];
      op1 = model_regs[word[`LOOPERS_RS_LSB +: $bits(reg_addr_t)]];
      op2 = word[`LOOPERS_IMM_BIT] ? imm_val
                                   : model_regs[word[`LOOPERS_RT_LSB +: $bits(reg_addr_t)]];
      val = model_alu(word[`LOOPERS_MODE_MSB:`LOOPERS_MODE_LSB], word[`LOOPERS_INV_BIT],
                      op1, op2);
      model_regs[rd] = val;
      exp_reg_q.push_back(rd);
      exp_val_q.push_back(val);
      exp_edge_q.push_back(cyc + 3);                     // Issue edge is cyc + 1
      issued++;
   endtask

   //////////////////////////////////////////////////
   // Output checks, run mid-cycle before driving
   //////////////////////////////////////////////////
   task automatic check_outputs();
      logic      pending;
      logic      due;
      reg_addr_t e_reg;
      data_t     e_val;
      int        e_edge;
      pending = exp_reg_q.size() > 0;
      due     = pending && (exp_edge_q[0] == cyc + 1);
      assert (!result_valid || pending) else begin
         $display("ERROR t=%0t: result_valid high with no instruction in flight", $time);
         errors++;
      end
      assert (result_valid || !due) else begin
         $display("ERROR t=%0t: result for r%0d did not arrive", $time, exp_reg_q[0]);
         errors++;
      end
      // Bubbles carry a zero result
      assert (result_valid || result == '0) else begin
         $display("FAILED t=%0t result: got %h expected %h with result_valid low",
                  $time, result, data_t'(0));
         errors++;
      end
      if (pending && (result_valid || due)) begin
         e_reg  = exp_reg_q.pop_front();
         e_val  = exp_val_q.pop_front();
         e_edge = exp_edge_q.pop_front();
         if (result_valid) begin
            checks++;
            assert (e_edge == cyc + 1) else begin
               $display("FAILED t=%0t arrival_edge: got %0d expected %0d",
                        $time, cyc + 1, e_edge);
               errors++;
            end
            assert (result_reg == e_reg) else begin
               $display("FAILED t=%0t result_reg: got %0d expected %0d",
                        $time, result_reg, e_reg);
               errors++;
            end
            assert (result == e_val) else begin
               $display("FAILED t=%0t result: got %h expected %h", $time, result, e_val);
               errors++;
            end
         end
      end
   endtask

   task automatic issue_instr(input instr_t word, input data_t imm_val);
      @(negedge clk);
      check_outputs();
      issue = 1'b1;
      instr = word;
      imm   = imm_val;
      model_issue(word, imm_val);
   endtask

   // Idle cycles carry junk on instr and imm
   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         check_outputs();
         issue = 1'b0;
         instr = instr_t'(rand32());
         imm   = data_t'(rand32());
      end
   endtask

   task automatic end_test(input string name);
      while (exp_reg_q.size() > 0) idle(1);              // Drain the pipe
      idle(2);                                           // Catch stray valids
      tests_run++;
      if (errors == test_err_start) begin
         tests_passed++;
         $display("test %0d %s: pass", tests_run, name);
      end else begin
         $display("test %0d %s: fail, %0d errors", tests_run, name, errors - test_err_start);
      end
      test_err_start = errors;
   endtask

   //////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////
   initial begin
      repeat (RESET_CYCLES + WATCHDOG_CYC) @(posedge clk);
      $display("ERROR: watchdog expired, %0d instructions issued, %0d results seen",
               issued, checks);
      $display("Test FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   initial begin
      logic [31:0] r;
      alu_mode_t   mode;
      logic        inv;
      reg_addr_t   rd;
      reg_addr_t   prev_rd;
      reg_addr_t   prev2_rd;
      rng_state = 32'h9ba30f50;
      cyc            = 0;
      errors         = 0;
      checks         = 0;
      issued         = 0;
      tests_run      = 0;
      tests_passed   = 0;
      test_err_start = 0;
      for (int i = 0; i < `LOOPERS_NREGS; i++) model_regs[i] = '0;
      reset = 1'b1;
      issue = 1'b0;
      instr = '0;
      imm   = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // 1. Quiet after reset, then r1 + r2 of cleared registers
      idle(6);
      issue_instr(make_instr(MODE_ADD, 1'b0, 1'b0, 3'd3, 3'd1, 3'd2), 16'h1234);
      end_test("reset and zero add");

      // 2. Immediate add, add plus one, subtract
      for (int k = 0; k < 24; k++) begin
         r = rand32();
         case (r[1:0])
            2'd0:    mode = MODE_ADD;
            2'd1:    mode = 3'b001;                      // Add alias
            default: mode = MODE_ADD1;
         endcase
         inv = (r[1:0] == 2'd3);                         // Subtract
         issue_instr(make_instr(mode, inv, 1'b1, r[4:2], r[7:5], r[10:8]), data_t'(rand32()));
         if (r[11]) idle(1);
      end
      end_test("immediate arithmetic");

      // 3. Logic ops on register pairs
      for (int k = 0; k < 24; k++) begin
         r = rand32();
         case (int'(r[7:0]) % 3)
            0:       mode = MODE_AND;
            1:       mode = MODE_OR;
            default: mode = MODE_XOR;
         endcase
         issue_instr(make_instr(mode, r[8], 1'b0, r[11:9], r[14:12], r[17:15]), 16'h0);
         if (r[18]) idle(1);
      end
      end_test("logic ops");

      // 4. NOT with junk operand 2, then every shift amount
      for (int k = 0; k < 4; k++) begin
         r = rand32();
         issue_instr(make_instr(MODE_NOT, r[0], r[1], r[4:2], r[7:5], r[10:8]),
                     data_t'(rand32()));
      end
      r = rand32();
      issue_instr(make_instr(MODE_AND, 1'b0, 1'b1, 3'd1, 3'd1, 3'd0), 16'h0000);
      issue_instr(make_instr(MODE_ADD, 1'b0, 1'b1, 3'd1, 3'd1, 3'd0), {1'b1, r[14:0]});
      issue_instr(make_instr(MODE_AND, 1'b0, 1'b1, 3'd2, 3'd2, 3'd0), 16'h0000);
      issue_instr(make_instr(MODE_ADD, 1'b0, 1'b1, 3'd2, 3'd2, 3'd0), {1'b0, r[30:16]});
      for (int amt = 0; amt < 16; amt++) begin
         for (int src = 1; src <= 2; src++) begin
            r = rand32();
            // Invert set on odd amounts, must not change the amount
            issue_instr(make_instr(MODE_SRA, amt[0], 1'b1, 3'd5, reg_addr_t'(src), 3'd0),
                        {r[11:0], amt[3:0]});
         end
      end
      end_test("not and shift");

      // 5. Dependent chains, gap 0 and 1 bypass, gap 2 register file
      for (int g = 0; g < 3; g++) begin
         prev_rd  = 3'd1;
         prev2_rd = 3'd2;
         for (int k = 0; k < 8; k++) begin
            r  = rand32();
            rd = r[2:0];
            issue_instr(make_instr(r[5:3], r[6], 1'b0, rd, prev_rd, prev2_rd), r[31:16]);
            prev2_rd = prev_rd;
            prev_rd  = rd;
            idle(g);
         end
      end
      end_test("dependent chains");

      // 6. Random words with random gaps
      for (int k = 0; k < 200; k++) begin
         issue_instr(instr_t'(rand32()), data_t'(rand32()));
         r = rand32();
         idle((r[1:0] == 2'd0) ? int'(r[3:2]) : 0);
      end
      end_test("random mix");

      // One result per issue overall
      assert (checks == issued) else begin
         $display("ERROR: %0d instructions issued but %0d results seen", issued, checks);
         errors++;
      end
      $display("summary: %0d of %0d tests passed, %0d results checked, %0d errors",
               tests_passed, tests_run, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+design
design/loopers_pkg.sv
design/reg_file.sv
design/alu.sv
design/instr_decode.sv
design/loopers_exec_top.sv
dv/loopers_exec_tb.sv

//--- Makefile
# Verilator build and run of the execute pipeline testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass if the log holds the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module loopers_exec_tb -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
